/* src.f */
photon_pkg.sv
fifo_if.sv
edge_detect.sv
photon_counter.sv
record_fifo.sv
record_writer.sv
photon_counter_top.sv
photon_counter_sva.sv
tb_photon_counter.sv

/* Bender.yml */
package:
  name: photon_counter

sources:
  - files:
      - photon_pkg.sv
      - fifo_if.sv
      - edge_detect.sv
      - photon_counter.sv
      - record_fifo.sv
      - record_writer.sv
      - photon_counter_top.sv
  - target: test
    files:
      - photon_counter_sva.sv
      - tb_photon_counter.sv

/* tb_photon_counter.sv */
`timescale 1ns/10ps

module tb_photon_counter;

    // Saturation alone needs 10000 cycles, the other tests under 2000.
    localparam int TIMEOUT_CYCLES = 20000;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          photon_pulse;
    logic                          sync_50hz;
    logic                          mem_req;
    logic [photon_pkg::ADDR_W-1:0] mem_addr;
    logic [photon_pkg::HALF_W-1:0] mem_data;
    logic                          mem_ack;
    logic [7:0]                    drop_count;

    logic [photon_pkg::HALF_W-1:0] mem_model [photon_pkg::BUF_HALVES]; // Ring image.
    logic [31:0] rng = 32'h7d51379c;
    logic        stall;            // Holds mem_ack low.
    logic        armed;            // Ack delay drawn for this request.
    int          ack_delay;
    int          halves_done = 0;  // Finished handshakes.
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          mark = 0;         // Error count at test start.
    int          exp_frame = 0;    // Frame index of the open period.
    int          exp_slot = 0;     // Next ring slot.
    int          exp_halves = 0;

    photon_counter_top dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////////////
    // Memory responder.
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (mem_ack) begin
            if (!mem_req) begin
                mem_ack     = 1'b0; // Phase 4.
                halves_done = halves_done + 1;
            end
        end else if (mem_req && !stall) begin
            if (!armed) begin
                rng       = xorshift32(rng);
                ack_delay = rng % 4; // 0 to 3 cycles.
                armed     = 1'b1;
            end
            if (ack_delay == 0) begin
                mem_model[mem_addr] = mem_data;
                mem_ack = 1'b1;
                armed   = 1'b0;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d clock cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus and checks.
    ////////////////////////////////////////
    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks = checks + 1;
        assert (got === exp) else begin
            $display("Error %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    // Record is {frame, count}, low half in the lower slot.
    task automatic expect_record(input int slot, input int frame, input int count);
        logic [31:0] word;
        word = {frame[photon_pkg::FRAME_W-1:0], count[photon_pkg::COUNT_W-1:0]};
        expect_equal(mem_model[slot % photon_pkg::BUF_HALVES], word[15:0],
                     $sformatf("low half, frame %0d", frame));
        expect_equal(mem_model[(slot + 1) % photon_pkg::BUF_HALVES], word[31:16],
                     $sformatf("high half, frame %0d", frame));
    endtask

    task automatic pulse_photons(input int n);
        repeat (n) begin
            photon_pulse = 1'b1;
            @(negedge clk);
            photon_pulse = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic pulse_sync();
        sync_50hz = 1'b1;
        @(negedge clk);
        sync_50hz = 1'b0;
        repeat (4) @(negedge clk); // Strobe is through the synchronizer.
    endtask

    task automatic wait_for_halves(input int target);
        while (halves_done < target) @(negedge clk);
    endtask

    // Close the open period, then check its record in the ring.
    task automatic close_period(input int count);
        pulse_sync();
        exp_halves = exp_halves + 2;
        wait_for_halves(exp_halves);
        expect_record(exp_slot, exp_frame, count);
        exp_slot  = (exp_slot + 2) % photon_pkg::BUF_HALVES;
        exp_frame = exp_frame + 1;
    endtask

    task automatic idle_after_reset();
        expect_equal(mem_req, 0, "mem_req after reset");
        expect_equal(drop_count, 0, "drop_count after reset");
        pulse_photons(5);               // Not started yet.
        repeat (20) @(negedge clk);
        expect_equal(halves_done, 0, "writes before first sync");
        pulse_sync();                   // Opens frame 0 only.
        repeat (20) @(negedge clk);
        expect_equal(halves_done, 0, "writes after first sync");
    endtask

    task automatic long_pulse_and_empty_frame();
        photon_pulse = 1'b1;
        repeat (50) @(negedge clk);
        photon_pulse = 1'b0;
        @(negedge clk);
        close_period(1);                // One edge.
        close_period(0);
    endtask

    task automatic back_pressure_drops();
        int base;
        base  = exp_frame;
        stall = 1'b1;
        for (int i = 1; i <= 7; i++) begin
            pulse_photons(i);
            pulse_sync();
        end
        // One record in the writer, FIFO_DEPTH in the FIFO.
        expect_equal(drop_count, 7 - (photon_pkg::FIFO_DEPTH + 1), "drop_count when stalled");
        expect_equal(halves_done, exp_halves, "writes when stalled");
        stall = 1'b0;
        wait_for_halves(exp_halves + 10);
        pulse_photons(2);
        pulse_sync();                   // Frame base+7, after the gap.
        exp_halves = exp_halves + 12;
        wait_for_halves(exp_halves);
        for (int i = 0; i < 5; i++) begin
            expect_record(exp_slot + 2 * i, base + i, i + 1);
        end
        expect_record(exp_slot + 10, base + 7, 2);
        exp_slot  = (exp_slot + 12) % photon_pkg::BUF_HALVES;
        exp_frame = base + 8;
    endtask

    task automatic ring_wraps();
        int first_slot;
        first_slot = exp_slot;
        for (int i = 1; i <= 9; i++) begin
            pulse_photons(i + 10);
            close_period(i + 10);       // Record 9 lands on record 1's slots.
        end
        @(negedge clk);                 // Pointer steps on the edge after ack falls.
        expect_equal(mem_addr, (first_slot + 2) % photon_pkg::BUF_HALVES, "pointer after wrap");
    endtask

    task automatic report_test(input string name);
        tests = tests + 1;
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        rst_n        = 1'b0;
        photon_pulse = 1'b0;
        sync_50hz    = 1'b0;
        mem_ack      = 1'b0;
        stall        = 1'b0;
        armed        = 1'b0;
        for (int a = 0; a < photon_pkg::BUF_HALVES; a++) begin
            mem_model[a] = 16'hc0d0 ^ a[15:0];
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        report_test("reset and idle");
        pulse_photons(37);
        close_period(37);
        report_test("count one period");
        long_pulse_and_empty_frame();
        report_test("long pulse and empty frame");
        pulse_photons(5000);
        close_period(4095);             // Full scale.
        report_test("count saturation");
        back_pressure_drops();
        report_test("back-pressure drops");
        ring_wraps();
        report_test("ring wrap");
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* photon_counter_sva.sv */
`timescale 1ns/10ps

module photon_counter_sva (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          req,   // Memory request.
    input logic                          ack,   // Memory acknowledge.
    input logic [photon_pkg::ADDR_W-1:0] addr,
    input logic [photon_pkg::HALF_W-1:0] data,
    input logic                          push,  // FIFO write side.
    input logic                          full,
    input logic                          pop,   // FIFO read side.
    input logic                          empty
);

    // Phase 1 may only start once ack has fallen.
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !$past(ack)) else $error("mem_req rose while mem_ack was high");

    // Address and word held for the whole request.
    req_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req && $past(req) |-> $stable(addr) && $stable(data))
        else $error("mem_addr or mem_data changed while mem_req was high");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full)) else $error("record pushed into a full FIFO");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty)) else $error("record popped from an empty FIFO");

endmodule

// Writer side: handshake and pop.
bind record_writer photon_counter_sva wr_sva_i (
    .clk (clk), .rst_n (rst_n), .req (mem_req), .ack (mem_ack),
    .addr (mem_addr), .data (mem_data), .push (1'b0), .full (1'b0),
    .pop (rec_in.pop), .empty (rec_in.empty)
);

// FIFO side: both pointers.
bind record_fifo photon_counter_sva fifo_sva_i (
    .clk (clk), .rst_n (rst_n), .req (1'b0), .ack (1'b0), .addr ('0), .data ('0),
    .push (rec_q.push), .full (rec_q.full), .pop (rec_q.pop), .empty (rec_q.empty)
);

/* photon_counter_top.sv */
`timescale 1ns/10ps

module photon_counter_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          photon_pulse, // Photon detector pin.
    input  logic                          sync_50hz,    // Frame sync pin.
    output logic                          mem_req,
    output logic [photon_pkg::ADDR_W-1:0] mem_addr,
    output logic [photon_pkg::HALF_W-1:0] mem_data,
    input  logic                          mem_ack,
    output logic [7:0]                    drop_count
);

    logic photon_rise; // Photon strobe.
    logic sync_rise;   // Sync strobe.

    fifo_if rec_if (); // Counter to writer.

    ////////////////////////////////////////
    // Input conditioning.
    ////////////////////////////////////////
    edge_detect ic_photon_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .sig_in (photon_pulse),
        .rise   (photon_rise)
    );

    edge_detect ic_sync_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .sig_in (sync_50hz),
        .rise   (sync_rise)
    );

    ////////////////////////////////////////
    // Record path.
    ////////////////////////////////////////
    photon_counter ic_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .photon_rise (photon_rise),
        .sync_rise   (sync_rise),
        .rec_out     (rec_if.producer),
        .drop_count  (drop_count)
    );

    record_fifo ic_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .rec_q (rec_if.fifo)
    );

    record_writer ic_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .rec_in   (rec_if.consumer),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .mem_ack  (mem_ack)
    );

endmodule

/* record_writer.sv */
`timescale 1ns/10ps

module record_writer (
    input  logic                          clk,
    input  logic                          rst_n,
    fifo_if.consumer                      rec_in,
    output logic                          mem_req,
    output logic [photon_pkg::ADDR_W-1:0] mem_addr,
    output logic [photon_pkg::HALF_W-1:0] mem_data,
    input  logic                          mem_ack
);

    logic [1:0]                    state;    // FSM state.
    logic                          half_sel; // 0 sends the low half.
    logic [photon_pkg::ADDR_W-1:0] addr;     // Ring write pointer.
    photon_pkg::photon_record_u    rec;      // Record in flight.

    // Pop on the first idle cycle with data.
    assign rec_in.pop = (state == photon_pkg::WR_IDLE) && !rec_in.empty;

    ////////////////////////////////////////
    // Memory port.
    ////////////////////////////////////////
    assign mem_req  = (state == photon_pkg::WR_REQ); // Held until ack.
    assign mem_addr = addr;
    assign mem_data = rec.halves[half_sel]; // Stable while in WR_REQ.

    // Capture the popped record.
    always_ff @(posedge clk) begin
        if (rec_in.pop) begin
            rec <= rec_in.rdata;
        end
    end

    ////////////////////////////////////////
    // Four-phase sequencing.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= photon_pkg::WR_IDLE;
            half_sel <= 1'b0;
            addr     <= '0;
        end else begin
            case (state)
                photon_pkg::WR_IDLE: begin
                    if (!rec_in.empty) begin
                        half_sel <= 1'b0;               // Low half first.
                        state    <= photon_pkg::WR_REQ; // Request next cycle.
                    end
                end
                photon_pkg::WR_REQ: begin
                    if (mem_ack) begin
                        state <= photon_pkg::WR_ACK; // Word stored, drop req.
                    end
                end
                photon_pkg::WR_ACK: begin
                    // Handshake closes when ack falls.
                    if (!mem_ack) begin
                        if (addr == photon_pkg::BUF_HALVES - 1) begin
                            addr <= '0; // Ring wraps.
                        end else begin
                            addr <= addr + 1'b1;
                        end
                        if (half_sel) begin
                            state <= photon_pkg::WR_IDLE; // Record done.
                        end else begin
                            half_sel <= 1'b1;
                            state    <= photon_pkg::WR_REQ;
                        end
                    end
                end
                default: state <= photon_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

/* record_fifo.sv */
`timescale 1ns/10ps

module record_fifo (
    input  logic  clk,
    input  logic  rst_n,
    fifo_if.fifo  rec_q
);

    photon_pkg::photon_record_u mem [photon_pkg::FIFO_DEPTH]; // Storage array.

    logic [$clog2(photon_pkg::FIFO_DEPTH)-1:0]   wr_ptr; // Next slot to write.
    logic [$clog2(photon_pkg::FIFO_DEPTH)-1:0]   rd_ptr; // Oldest record.
    logic [$clog2(photon_pkg::FIFO_DEPTH+1)-1:0] occ;    // Records held.
    logic                                        do_push;
    logic                                        do_pop;

    assign do_push = rec_q.push & ~rec_q.full;  // Guarded.
    assign do_pop  = rec_q.pop  & ~rec_q.empty;

    ////////////////////////////////////////
    // Pointers and occupancy.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth.
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                occ <= occ + 1'b1;
            end else if (do_pop && !do_push) begin
                occ <= occ - 1'b1;
            end
        end
    end

    // Data array.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= rec_q.wdata;
        end
    end

    // Oldest record is always on the output.
    assign rec_q.rdata = mem[rd_ptr];
    assign rec_q.empty = (occ == 0);
    assign rec_q.full  = (occ == photon_pkg::FIFO_DEPTH);

endmodule

/* photon_counter.sv */
`timescale 1ns/10ps

module photon_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            photon_rise, // Strobe per photon.
    input  logic            sync_rise,   // Strobe per frame sync.
    fifo_if.producer        rec_out,
    output logic [7:0]      drop_count   // Records lost to a full FIFO.
);

    logic                              started; // First sync seen.
    logic [photon_pkg::COUNT_W-1:0]    count;   // Running count of this period.
    logic [photon_pkg::FRAME_W-1:0]    frame;   // Index of the running period.
    photon_pkg::photon_record_u        next_rec;

    // Record for the period that closes now.
    always_comb begin
        next_rec.fields.frame = frame;
        next_rec.fields.count = count;
    end

    ////////////////////////////////////////
    // Counting and period close.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started      <= 1'b0;
            count        <= '0;
            frame        <= '0;
            drop_count   <= '0;
            rec_out.push <= 1'b0;
        end else begin
            rec_out.push <= 1'b0; // Single-cycle push.
            if (sync_rise) begin
                started <= 1'b1;
                // A photon on the sync cycle belongs to the new period.
                count   <= {{(photon_pkg::COUNT_W-1){1'b0}}, photon_rise};
                if (started) begin
                    frame <= frame + 1'b1; // Advances even when dropped.
                    if (!rec_out.full) begin
                        rec_out.push <= 1'b1;
                    end else if (drop_count != 8'hff) begin
                        drop_count <= drop_count + 1'b1; // Saturates.
                    end
                end
            end else if (started && photon_rise && count != '1) begin
                count <= count + 1'b1; // Holds at full scale.
            end
        end
    end

    // Payload for the push of the next cycle.
    always_ff @(posedge clk) begin
        if (sync_rise && started) begin
            rec_out.wdata <= next_rec;
        end
    end

endmodule

/* edge_detect.sv */
`timescale 1ns/10ps

module edge_detect (
    input  logic clk,
    input  logic rst_n,
    input  logic sig_in,   // Asynchronous pin.
    output logic rise      // One-cycle strobe.
);

    logic sync_1; // First flop, may go metastable.
    logic sync_2; // Settled copy.
    logic prev;   // Synchronized value one cycle back.

    ////////////////////////////////////////
    // Synchronizer and history.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            prev   <= 1'b0;
        end else begin
            sync_1 <= sig_in;
            sync_2 <= sync_1;
            prev   <= sync_2; // Lags sync_2 by one cycle.
        end
    end

    // Low to high on the synchronized value.
    // A long high level gives only one strobe.
    assign rise = sync_2 & ~prev;

endmodule

/* fifo_if.sv */
`timescale 1ns/10ps

interface fifo_if;

    // Write side.
    logic                       push;
    photon_pkg::photon_record_u wdata;
    logic                       full;

    // Read side, first word falls through.
    logic                       pop;
    photon_pkg::photon_record_u rdata;
    logic                       empty;

    modport producer (output push, output wdata, input full);

    modport fifo (
        input  push, input  wdata, output full,
        input  pop,  output rdata, output empty
    );

    modport consumer (output pop, input rdata, input empty);

endinterface

/* photon_pkg.sv */
package photon_pkg;

    ////////////////////////////////////////
    // Record format.
    ////////////////////////////////////////
    localparam int COUNT_W = 12; // Photon count field.
    localparam int FRAME_W = 20; // Frame index field.
    localparam int HALF_W  = 16; // One memory word.

    ////////////////////////////////////////
    // Buffering and memory ring.
    ////////////////////////////////////////
    localparam int FIFO_DEPTH = 4;  // Records held between counter and writer.
    localparam int BUF_HALVES = 16; // Ring size in halfwords.
    localparam int ADDR_W     = 4;  // Enough to index the ring.

    // Writer FSM encodings.
    localparam logic [1:0] WR_IDLE = 2'd0; // Waiting for a record.
    localparam logic [1:0] WR_REQ  = 2'd1; // Request raised, waiting for ack.
    localparam logic [1:0] WR_ACK  = 2'd2; // Request dropped, waiting for ack low.

    // One 32-bit record.
    // The counter fills it by field, the writer sends it by halfword.
    typedef union packed {
        struct packed {
            logic [FRAME_W-1:0] frame; // Upper bits.
            logic [COUNT_W-1:0] count; // Lower bits.
        } fields;
        logic [1:0][HALF_W-1:0] halves; // Index 0 is the low half.
    } photon_record_u;

endpackage
